// File: design/compress_params.svh
/*
 * Widths, counts and the modulus shared by the compression engine.
 * Include this header wherever the macros are needed.
 */
`ifndef COMPRESS_PARAMS_SVH
`define COMPRESS_PARAMS_SVH

// Datapath shape
`define COEFF_PER_CLK 4
`define COEFF_W 12
`define KEM_Q 3329

// One command covers four polynomials of 64 beats each
`define NUM_POLY 4
`define POLY_BEATS 64

// Memory and output side
`define MEM_ADDR_W 16
`define WR_DATA_W 32
`define PACK_BUF_W 80

`endif

// File: design/kem_math_pkg.sv
/*
 * Arithmetic types of the compression engine: coefficients, beats,
 * the compression mode and the per-coefficient bit count.
 */
`include "compress_params.svh"

package kem_math_pkg;

    // One coefficient, always below the modulus
    typedef logic [`COEFF_W-1:0] coeff_t;

    // Four coefficients, lane 0 in the lowest bits
    typedef logic [`COEFF_PER_CLK*`COEFF_W-1:0] coeff_beat_t;

    typedef enum logic [1:0] {
        COMP_D1  = 2'd0,
        COMP_D5  = 2'd1,
        COMP_D11 = 2'd2,
        COMP_D12 = 2'd3
    } comp_mode_t;

    // Number of valid bits per compressed coefficient
    typedef logic [3:0] comp_bits_t;

endpackage

// File: design/kem_mem_pkg.sv
/*
 * Memory side types: addresses, the read request, the write strobe
 * and the compression command.
 */
`include "compress_params.svh"

package kem_mem_pkg;

    typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

    // Data returns exactly one cycle after rd_en
    typedef struct packed {
        logic      rd_en;
        mem_addr_t addr;
    } mem_rd_req_t;

    typedef struct packed {
        logic                  wr_en;
        mem_addr_t             addr;
        logic [`WR_DATA_W-1:0] data;
    } api_wr_t;

    typedef struct packed {
        kem_math_pkg::comp_mode_t mode;
        mem_addr_t                src_base;
        mem_addr_t                dst_base;
    } comp_cmd_t;

endpackage

// File: design/compress_read_ctrl.sv
/*
 * Read controller. Walks the 256 source beats of a command and holds off
 * new reads while the packer has no room for another beat.
 */
`timescale 1ns/10ps
`include "compress_params.svh"

module compress_read_ctrl (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      zeroize_i,
    input  logic                      start_i,
    input  kem_mem_pkg::mem_addr_t    src_base_i,
    input  logic                      pack_ready_i,
    output kem_mem_pkg::mem_rd_req_t  mem_rd_req_o,
    output logic                      beat_valid_o,
    output logic                      stall_o,
    output logic                      read_done_o
);

    localparam int TOTAL_BEATS = `NUM_POLY * `POLY_BEATS;
    localparam int CNT_W = $clog2(TOTAL_BEATS);

    typedef enum logic [1:0] {IDLE, READ, STALL, DONE} read_ctrl_state_t;

    read_ctrl_state_t       state_q, state_next;
    kem_mem_pkg::mem_addr_t addr_q;
    logic [CNT_W-1:0]       cnt_q;
    logic                   rd_en;
    logic                   last_read;
    logic                   hold_q;

    // A read goes out only when the packer can take the returning beat
    assign rd_en = ((state_q == READ) || (state_q == STALL)) && pack_ready_i;
    assign last_read = (cnt_q == CNT_W'(TOTAL_BEATS - 1));

    assign mem_rd_req_o.rd_en = rd_en;
    assign mem_rd_req_o.addr = addr_q;

    // A beat arriving while the packer is full must wait in the skid register
    assign stall_o = !pack_ready_i;
    assign read_done_o = (state_q == DONE) && !beat_valid_o && !hold_q;

    always_comb begin
        state_next = state_q;
        unique case (state_q)
            IDLE, DONE: begin
                if (start_i) state_next = READ;
            end
            READ, STALL: begin
                if (!pack_ready_i) state_next = STALL;
                else if (last_read) state_next = DONE;
                else state_next = READ;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= IDLE;
            addr_q <= '0;
            cnt_q <= '0;
            beat_valid_o <= 1'b0;
            hold_q <= 1'b0;
        end else if (zeroize_i) begin
            state_q <= IDLE;
            addr_q <= '0;
            cnt_q <= '0;
            beat_valid_o <= 1'b0;
            hold_q <= 1'b0;
        end else begin
            state_q <= state_next;
            beat_valid_o <= rd_en;
            // Tracks a beat parked in the lanes until it is replayed
            hold_q <= stall_o && (hold_q || beat_valid_o);
            if (start_i) begin
                addr_q <= src_base_i;
                cnt_q <= '0;
            end else if (rd_en) begin
                addr_q <= addr_q + 1'b1;
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // A beat returning while another is parked would overwrite the skid register
    no_read_when_full: assert property (@(posedge clk) disable iff (!reset_n)
        beat_valid_o |-> !hold_q)
        else $error("beat returned while the skid register was still full");

endmodule

// File: design/compress_lanes.sv
/*
 * Four compression lanes fed from the memory beat or from a one-entry
 * skid register. Output is the four results packed at d bits each.
 */
`timescale 1ns/10ps
`include "compress_params.svh"

module compress_lanes (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        zeroize_i,
    input  kem_math_pkg::comp_mode_t    mode_i,
    input  kem_math_pkg::coeff_beat_t   beat_i,
    input  logic                        beat_valid_i,
    input  logic                        stall_i,
    output logic [`COEFF_PER_CLK*`COEFF_W-1:0] lane_bits_o,
    output logic                        lane_valid_o,
    output kem_math_pkg::comp_bits_t    lane_width_o
);

    localparam int BEAT_W = `COEFF_PER_CLK * `COEFF_W;
    // Widest dividend is x * 2^11 plus the rounding offset
    localparam int NUM_W = `COEFF_W + 11;
    localparam int RECIP_SHIFT = 24;
    localparam int RECIP = (1 << RECIP_SHIFT) / `KEM_Q;
    localparam int PROD_W = NUM_W + 13;

    kem_math_pkg::coeff_beat_t skid_q, beat_sel;
    logic                      skid_valid_q;
    kem_math_pkg::coeff_t      mask;
    kem_math_pkg::coeff_t      comp [`COEFF_PER_CLK];

    assign beat_sel = skid_valid_q ? skid_q : beat_i;
    assign lane_valid_o = !stall_i && (skid_valid_q || beat_valid_i);

    always_comb begin
        unique case (mode_i)
            kem_math_pkg::COMP_D1:  lane_width_o = 4'd1;
            kem_math_pkg::COMP_D5:  lane_width_o = 4'd5;
            kem_math_pkg::COMP_D11: lane_width_o = 4'd11;
            default:                lane_width_o = 4'd12;
        endcase
    end

    assign mask = ~({`COEFF_W{1'b1}} << lane_width_o);

    for (genvar i = 0; i < `COEFF_PER_CLK; i++) begin : g_lane
        kem_math_pkg::coeff_t x;
        logic [NUM_W-1:0]     num, rem;
        logic [PROD_W-1:0]    prod;
        kem_math_pkg::coeff_t quot;

        assign x = beat_sel[i*`COEFF_W +: `COEFF_W];

        always_comb begin
            // round(2^d x / q) as floor((2^d x + (q-1)/2) / q)
            num = (NUM_W'(x) << lane_width_o) + NUM_W'(`KEM_Q / 2);
            prod = PROD_W'(num) * PROD_W'(RECIP);
            quot = `COEFF_W'(prod >> RECIP_SHIFT);
            // The reciprocal estimate is at most one below the true quotient
            rem = num - NUM_W'(quot) * NUM_W'(`KEM_Q);
            if (rem >= NUM_W'(`KEM_Q)) quot = quot + 1'b1;
            comp[i] = (mode_i == kem_math_pkg::COMP_D12) ? x : (quot & mask);
        end

        coeff_in_range: assert property (@(posedge clk) disable iff (!reset_n)
            beat_valid_i |-> (beat_i[i*`COEFF_W +: `COEFF_W] < `COEFF_W'(`KEM_Q)))
            else $error("coefficient %0d not below q", i);
    end

    always_comb begin
        lane_bits_o = '0;
        for (int i = 0; i < `COEFF_PER_CLK; i++) begin
            lane_bits_o = lane_bits_o | (BEAT_W'(comp[i]) << (i * int'(lane_width_o)));
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            skid_valid_q <= 1'b0;
        end else if (zeroize_i) begin
            skid_valid_q <= 1'b0;
        end else if (stall_i && beat_valid_i) begin
            skid_valid_q <= 1'b1;
        end else if (!stall_i) begin
            skid_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (zeroize_i) skid_q <= '0;
        else if (stall_i && beat_valid_i) skid_q <= beat_i;
    end

endmodule

// File: design/compress_packer.sv
/*
 * Bit packer. Appends 4*d bits per lane beat above the buffered bits and
 * hands out the low 32 bits as a word whenever that many are present.
 */
`timescale 1ns/10ps
`include "compress_params.svh"

module compress_packer (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               zeroize_i,
    input  logic [`COEFF_PER_CLK*`COEFF_W-1:0] lane_bits_i,
    input  logic                               lane_valid_i,
    input  kem_math_pkg::comp_bits_t           lane_width_i,
    output logic                               pack_ready_o,
    output logic                               word_valid_o,
    output logic [`WR_DATA_W-1:0]              word_o
);

    localparam int FILL_W = $clog2(`PACK_BUF_W + 1);

    logic [`PACK_BUF_W-1:0] buf_q;
    logic [`PACK_BUF_W-1:0] kept;
    logic [`PACK_BUF_W-1:0] incoming;
    logic [FILL_W-1:0]      fill_q;
    logic [FILL_W-1:0]      kept_fill;
    logic [FILL_W-1:0]      add_bits;

    // A word leaves in the cycle after the beat that completed it
    assign word_valid_o = (fill_q >= FILL_W'(`WR_DATA_W));
    assign word_o = buf_q[`WR_DATA_W-1:0];

    // With at most 32 bits held, one word drains while a full beat lands,
    // so the 80-bit buffer never overflows
    assign pack_ready_o = (fill_q <= FILL_W'(`WR_DATA_W));

    always_comb begin
        if (word_valid_o) begin
            kept = buf_q >> `WR_DATA_W;
            kept_fill = fill_q - FILL_W'(`WR_DATA_W);
        end else begin
            kept = buf_q;
            kept_fill = fill_q;
        end

        if (lane_valid_i) begin
            add_bits = FILL_W'({lane_width_i, 2'b00});
            incoming = `PACK_BUF_W'(lane_bits_i) << kept_fill;
        end else begin
            add_bits = '0;
            incoming = '0;
        end
    end

    // Bits above the fill count stay zero, so new bits are simply OR-ed in
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            buf_q <= '0;
            fill_q <= '0;
        end else if (zeroize_i) begin
            buf_q <= '0;
            fill_q <= '0;
        end else begin
            buf_q <= kept | incoming;
            fill_q <= kept_fill + add_bits;
        end
    end

    fill_in_range: assert property (@(posedge clk) disable iff (!reset_n)
        fill_q <= FILL_W'(`PACK_BUF_W))
        else $error("packer buffer overflow, fill %0d", fill_q);

endmodule

// File: design/compress_top.sv
/*
 * Compression engine top. Takes one command over a four-phase req/ack
 * handshake, compresses four polynomials and writes the packed words.
 */
`timescale 1ns/10ps
`include "compress_params.svh"

module compress_top (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        zeroize_i,
    input  logic                        cmd_req_i,
    input  kem_mem_pkg::comp_cmd_t      cmd_i,
    output logic                        cmd_ack_o,
    output kem_mem_pkg::mem_rd_req_t    mem_rd_req_o,
    input  kem_math_pkg::coeff_beat_t   mem_rd_data_i,
    output kem_mem_pkg::api_wr_t        api_wr_o
);

    logic                      busy_q;
    logic                      accept;
    logic                      done;
    kem_math_pkg::comp_mode_t  mode_q;
    kem_mem_pkg::mem_addr_t    wr_addr_q;
    logic                      beat_valid, stall, read_done;
    logic [`COEFF_PER_CLK*`COEFF_W-1:0] lane_bits;
    logic                      lane_valid;
    kem_math_pkg::comp_bits_t  lane_width;
    logic                      pack_ready, word_valid;
    logic [`WR_DATA_W-1:0]     word;

    // New work only after the previous handshake has fully closed
    assign accept = cmd_req_i && !busy_q && !cmd_ack_o;
    assign done = busy_q && read_done && !word_valid;

    assign api_wr_o.wr_en = word_valid;
    assign api_wr_o.addr = wr_addr_q;
    assign api_wr_o.data = word;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_q <= 1'b0;
            cmd_ack_o <= 1'b0;
            wr_addr_q <= '0;
        end else if (zeroize_i) begin
            busy_q <= 1'b0;
            cmd_ack_o <= 1'b0;
            wr_addr_q <= '0;
        end else begin
            if (accept) busy_q <= 1'b1;
            else if (done) busy_q <= 1'b0;

            if (done) cmd_ack_o <= 1'b1;
            else if (!cmd_req_i) cmd_ack_o <= 1'b0;

            if (accept) wr_addr_q <= cmd_i.dst_base;
            else if (word_valid) wr_addr_q <= wr_addr_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (zeroize_i) mode_q <= kem_math_pkg::COMP_D1;
        else if (accept) mode_q <= cmd_i.mode;
    end

    compress_read_ctrl i_read_ctrl (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .start_i      (accept),
        .src_base_i   (cmd_i.src_base),
        .pack_ready_i (pack_ready),
        .mem_rd_req_o (mem_rd_req_o),
        .beat_valid_o (beat_valid),
        .stall_o      (stall),
        .read_done_o  (read_done)
    );

    compress_lanes i_lanes (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .mode_i       (mode_q),
        .beat_i       (mem_rd_data_i),
        .beat_valid_i (beat_valid),
        .stall_i      (stall),
        .lane_bits_o  (lane_bits),
        .lane_valid_o (lane_valid),
        .lane_width_o (lane_width)
    );

    compress_packer i_packer (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .lane_bits_i  (lane_bits),
        .lane_valid_i (lane_valid),
        .lane_width_i (lane_width),
        .pack_ready_o (pack_ready),
        .word_valid_o (word_valid),
        .word_o       (word)
    );

    ack_needs_req: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(cmd_ack_o) |-> cmd_req_i)
        else $error("ack raised without a pending request");

endmodule

// File: verification/tb_clock_gen.sv
/*
 * Testbench clock and reset source: 10 ns clock, reset held low
 * for 16 cycles and released on a falling edge.
 */
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk_o,
    output logic reset_n_o
);

    initial begin
        clk_o = 1'b0;
        reset_n_o = 1'b0;
        repeat (16) @(posedge clk_o);
        @(negedge clk_o);
        reset_n_o = 1'b1;
    end

    always #5 clk_o = ~clk_o;

endmodule

// File: verification/compress_tb.sv
/*
 * Testbench for the compression engine. Drives commands on the falling edge,
 * models the memory and checks every read address and written word.
 */
`timescale 1ns/10ps
`include "compress_params.svh"

module compress_tb;

    localparam int CYCLE_LIMIT = 20 * 500;
    localparam int TOTAL_BEATS = `NUM_POLY * `POLY_BEATS;
    localparam logic [15:0] EDGE_BASE = 16'hF000;

    logic clk;
    logic reset_n;
    logic zeroize;
    logic cmd_req;
    kem_mem_pkg::comp_cmd_t    cmd;
    logic cmd_ack;
    kem_mem_pkg::mem_rd_req_t  rd_req;
    kem_math_pkg::coeff_beat_t rd_data;
    kem_mem_pkg::api_wr_t      wr;

    kem_math_pkg::coeff_beat_t mem [0:65535];
    logic [31:0] rng_state;
    logic [31:0] exp_words [$];
    int          wr_count;
    int          rd_count;
    logic [15:0] exp_src;
    logic [15:0] exp_dst;
    logic        quiet;
    logic        ack_prev;
    logic        pend_en;
    logic [15:0] pend_addr;
    int          cycles;

    tb_clock_gen i_clock_gen (
        .clk_o     (clk),
        .reset_n_o (reset_n)
    );

    compress_top i_dut (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize_i     (zeroize),
        .cmd_req_i     (cmd_req),
        .cmd_i         (cmd),
        .cmd_ack_o     (cmd_ack),
        .mem_rd_req_o  (rd_req),
        .mem_rd_data_i (rd_data),
        .api_wr_o      (wr)
    );

    task automatic fail_check(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        $display("Some tests failed");
        $fatal(1, "stopping at first error");
    endtask

    function automatic logic [31:0] next_random();
        logic [31:0] s;
        s = rng_state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rng_state = s;
        return s;
    endfunction

    function automatic int mode_bits(input kem_math_pkg::comp_mode_t m);
        case (m)
            kem_math_pkg::COMP_D1:  return 1;
            kem_math_pkg::COMP_D5:  return 5;
            kem_math_pkg::COMP_D11: return 11;
            default:                return 12;
        endcase
    endfunction

    // round(2^d x / q) written as floor((2^(d+1) x + q) / 2q), then mod 2^d
    function automatic int compress_ref(input int x, input int d);
        int r;
        if (d == 12) return x;
        r = ((x << (d + 1)) + `KEM_Q) / (2 * `KEM_Q);
        return r % (1 << d);
    endfunction

    // Values on both sides of the rounding boundaries for d = 1, 5 and 11
    function automatic int edge_coeff(input int j);
        int dl, k, v;
        if (j == 0) return 0;
        if (j == 1) return `KEM_Q - 1;
        case ((j >> 2) % 3)
            0:       dl = 1;
            1:       dl = 5;
            default: dl = 11;
        endcase
        k = (j >> 4) & ((1 << dl) - 1);
        v = (((2 * k + 1) * `KEM_Q) >> (dl + 1)) + (j % 3) - 1;
        if (v < 0) v = 0;
        if (v > `KEM_Q - 1) v = `KEM_Q - 1;
        return v;
    endfunction

    task automatic fill_memory();
        kem_math_pkg::coeff_beat_t beat;
        for (int a = 0; a < 65536; a++) begin
            for (int l = 0; l < `COEFF_PER_CLK; l++) begin
                beat[l*`COEFF_W +: `COEFF_W] = `COEFF_W'(next_random() % `KEM_Q);
            end
            mem[a] = beat;
        end
        for (int b = 0; b < TOTAL_BEATS; b++) begin
            for (int l = 0; l < `COEFF_PER_CLK; l++) begin
                beat[l*`COEFF_W +: `COEFF_W] = `COEFF_W'(edge_coeff(b * 4 + l));
            end
            mem[EDGE_BASE + 16'(b)] = beat;
        end
    endtask

    // Expected word stream, packed LSB first with lane 0 of each beat first
    task automatic build_expected(input int d, input logic [15:0] src);
        logic [63:0] acc;
        int          fill;
        int          c;
        kem_math_pkg::coeff_beat_t beat;
        exp_words.delete();
        acc = '0;
        fill = 0;
        for (int b = 0; b < TOTAL_BEATS; b++) begin
            beat = mem[src + 16'(b)];
            for (int l = 0; l < `COEFF_PER_CLK; l++) begin
                c = compress_ref(int'(beat[l*`COEFF_W +: `COEFF_W]), d);
                acc = acc | (64'(c) << fill);
                fill = fill + d;
                if (fill >= 32) begin
                    exp_words.push_back(acc[31:0]);
                    acc = acc >> 32;
                    fill = fill - 32;
                end
            end
        end
    endtask

    task automatic start_command(input kem_math_pkg::comp_mode_t mode,
                                 input logic [15:0] src, input logic [15:0] dst);
        build_expected(mode_bits(mode), src);
        wr_count = 0;
        rd_count = 0;
        exp_src = src;
        exp_dst = dst;
        cmd.mode = mode;
        cmd.src_base = src;
        cmd.dst_base = dst;
        cmd_req = 1'b1;
    endtask

    task automatic run_command(input kem_math_pkg::comp_mode_t mode,
                               input logic [15:0] src, input logic [15:0] dst);
        int d;
        d = mode_bits(mode);
        start_command(mode, src, dst);
        do @(negedge clk); while (!cmd_ack);
        assert (wr_count == 32 * d)
            else fail_check($sformatf("mode d=%0d wrote %0d words, expected %0d",
                                      d, wr_count, 32 * d));
        assert (rd_count == TOTAL_BEATS)
            else fail_check($sformatf("%0d reads issued, expected %0d",
                                      rd_count, TOTAL_BEATS));
        // Requester drops the request one cycle after it sees the ack
        @(negedge clk);
        assert (cmd_ack) else fail_check("ack dropped while request still high");
        cmd_req = 1'b0;
        @(negedge clk);
        assert (!cmd_ack) else fail_check("ack still high after request dropped");
    endtask

    // Memory answers one cycle after each request; outputs checked where stable
    always @(negedge clk) begin
        if (reset_n) begin
            if (pend_en) rd_data = mem[pend_addr];
            pend_en = rd_req.rd_en;
            pend_addr = rd_req.addr;

            if (quiet) begin
                assert (!wr.wr_en && !rd_req.rd_en)
                    else fail_check("memory activity after zeroize");
            end
            if (cmd_ack && !ack_prev) begin
                assert (cmd_req) else fail_check("ack rose without a request");
            end
            ack_prev = cmd_ack;

            if (rd_req.rd_en) begin
                assert (rd_count < TOTAL_BEATS)
                    else fail_check("more reads than one command needs");
                assert (rd_req.addr == exp_src + 16'(rd_count))
                    else fail_check($sformatf("read addr %h, expected %h",
                                              rd_req.addr, exp_src + 16'(rd_count)));
                rd_count++;
            end
            if (wr.wr_en) begin
                assert (wr_count < exp_words.size())
                    else fail_check("more writes than the model expects");
                assert (wr.addr == exp_dst + 16'(wr_count))
                    else fail_check($sformatf("write addr %h, expected %h",
                                              wr.addr, exp_dst + 16'(wr_count)));
                assert (wr.data == exp_words[wr_count])
                    else fail_check($sformatf("word %0d is %h, expected %h",
                                              wr_count, wr.data, exp_words[wr_count]));
                wr_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [31:0] r;
        zeroize = 1'b0;
        cmd_req = 1'b0;
        cmd = '0;
        rd_data = '0;
        quiet = 1'b0;
        ack_prev = 1'b0;
        pend_en = 1'b0;
        pend_addr = '0;
        cycles = 0;
        wr_count = 0;
        rd_count = 0;
        exp_src = '0;
        exp_dst = '0;
        rng_state = 32'h8f1c_c037;
        fill_memory();

        @(posedge reset_n);
        assert (!cmd_ack && !wr.wr_en && !rd_req.rd_en)
            else fail_check("outputs not idle after reset");

        // Edge coefficients in every mode, commands back to back
        run_command(kem_math_pkg::COMP_D1, EDGE_BASE, 16'h0100);
        run_command(kem_math_pkg::COMP_D5, EDGE_BASE, 16'h0200);
        run_command(kem_math_pkg::COMP_D11, EDGE_BASE, 16'h0400);
        run_command(kem_math_pkg::COMP_D12, EDGE_BASE, 16'h0800);

        for (int n = 0; n < 8; n++) begin
            r = next_random();
            run_command(kem_math_pkg::comp_mode_t'(r[1:0]), r[15:0], r[31:16]);
        end

        // Zeroize in the middle of a 12-bit command
        r = next_random();
        start_command(kem_math_pkg::COMP_D12, r[15:0], r[31:16]);
        repeat (100) @(negedge clk);
        zeroize = 1'b1;
        cmd_req = 1'b0;
        @(negedge clk);
        zeroize = 1'b0;
        quiet = 1'b1;
        repeat (40) @(negedge clk);
        quiet = 1'b0;
        assert (!cmd_ack) else fail_check("ack high after zeroize");

        r = next_random();
        run_command(kem_math_pkg::COMP_D11, r[15:0], r[31:16]);

        $display("All tests passed");
        $finish;
    end

endmodule

// File: all.f
+incdir+design
design/kem_math_pkg.sv
design/kem_mem_pkg.sv
design/compress_read_ctrl.sv
design/compress_lanes.sv
design/compress_packer.sv
design/compress_top.sv
verification/tb_clock_gen.sv
verification/compress_tb.sv

// File: Makefile
# Verilator build and run of the compression engine testbench.
# Override any variable on the command line, e.g. make sim TOP=compress_tb

VERILATOR ?= verilator
TOP       ?= compress_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
